// File: Bender.yml
package:
  name: uart_rx

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rx_ctrl_pkg.sv
      - verilog/rx_data_pkg.sv
      - verilog/rx_frame_fsm.sv
      - verilog/rx_bit_timer.sv
      - verilog/rx_shift_register.sv
      - verilog/rx_holding_register.sv
      - verilog/uart_rx_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/uart_rx_checker.sv
      - bench/tb_uart_rx.sv

// File: bench/tb_uart_rx.sv
// testbench: clock, reset, LFSR stimulus, serial frame driver, byte model and checks
`include "uart_rx_settings.svh"

module tb_uart_rx;

    localparam int NUM_FRAMES     = 60;
    localparam int RESET_CYCLES   = 5;
    localparam int GAP_CYCLES     = 4;
    localparam int SETTLE_CYCLES  = 20;
    // 10 bits, worst glitch with settle, gap, handshake, rounded up
    localparam int FRAME_BUDGET   = 220;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + (NUM_FRAMES + 1) * FRAME_BUDGET + 200;

    logic                       clk;
    logic                       rst_n;
    logic                       rxd;
    logic                       rdy;
    logic [`UART_DATA_BITS-1:0] data;
    logic                       vld;
    logic                       frame_err;
    logic                       overrun;

    logic [15:0]                lfsr;
    // model of the holding register
    logic [`UART_DATA_BITS-1:0] exp_q[$];
    logic                       exp_overrun;
    int                         exp_ferr;
    int                         seen_ferr;
    int                         error_count;
    int                         cycle_count;
    logic                       prev_vld;
    logic                       prev_rdy;
    logic [`UART_DATA_BITS-1:0] prev_data;

    uart_rx_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .rxd       (rxd),
        .rdy       (rdy),
        .data      (data),
        .vld       (vld),
        .frame_err (frame_err),
        .overrun   (overrun)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // helpers
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            error_count++;
            $display("** Error at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    // called on a falling edge, returns on one
    task automatic hold_line(input logic level, input int cycles);
        rxd = level;
        repeat (cycles) @(negedge clk);
    endtask

    // start, data LSB first, stop, idle gap
    task automatic send_frame(input logic [7:0] value, input logic stop_level);
        hold_line(1'b0, `UART_OVERSAMPLE);
        for (int b = 0; b < `UART_DATA_BITS; b++)
            hold_line(value[b], `UART_OVERSAMPLE);
        hold_line(stop_level, `UART_OVERSAMPLE);
        hold_line(1'b1, GAP_CYCLES);
    endtask

    task automatic check_outputs(input string where);
        check_value(vld, exp_q.size() != 0, {where, ": vld"});
        if (exp_q.size() != 0)
            check_value(data, exp_q[0], {where, ": held data"});
        check_value(overrun, exp_overrun, {where, ": overrun"});
        check_value(seen_ferr, exp_ferr, {where, ": frame_err count"});
    endtask

    // one rdy cycle after a delay
    task automatic take_byte(input int delay);
        repeat (delay) @(negedge clk);
        check_outputs("before rdy");
        rdy = 1'b1;
        @(negedge clk);
        rdy = 1'b0;
        void'(exp_q.pop_front());
        exp_overrun = 1'b0;
        check_outputs("after rdy");
    endtask

    ////////////////////
    // monitors
    // pre-edge values, stable since the falling edge
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (frame_err)
                seen_ferr++;
            if (prev_vld && !prev_rdy)
            begin
                check_value(vld, 1'b1, "vld dropped without rdy");
                check_value(data, prev_data, "data moved while held");
            end
            if (prev_vld && prev_rdy)
                check_value(vld, 1'b0, "vld high after rdy");
        end
        prev_vld  <= vld;
        prev_rdy  <= rdy;
        prev_data <= data;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("timeout: frames not finished after %0d cycles", cycle_count);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    ////////////////////
    // main sequence
    initial
    begin : main_flow
        logic [7:0] value;
        logic [7:0] pick;
        logic [7:0] glitch_len;
        logic [7:0] delay;
        logic       bad_stop;
        logic       glitch;

        lfsr        = 16'd26;
        rxd         = 1'b1;
        rdy         = 1'b0;
        rst_n       = 1'b0;
        exp_overrun = 1'b0;
        exp_ferr    = 0;
        seen_ferr   = 0;
        error_count = 0;
        cycle_count = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value(vld, 1'b0, "vld after reset");
        check_value(frame_err, 1'b0, "frame_err after reset");
        check_value(overrun, 1'b0, "overrun after reset");

        for (int i = 0; i < NUM_FRAMES; i++)
        begin
            draw_bits(8, value);
            draw_bits(3, pick);
            bad_stop = (pick == 0);
            draw_bits(3, pick);
            glitch = (pick == 0);
            draw_bits(3, glitch_len);
            draw_bits(3, delay);
            // first frame right after reset is always clean
            if (i == 0)
            begin
                bad_stop = 1'b0;
                glitch   = 1'b0;
            end
            // short low pulse, shorter than half a bit
            if (glitch)
            begin
                hold_line(1'b0, (glitch_len == 0) ? 1 : int'(glitch_len));
                hold_line(1'b1, SETTLE_CYCLES);
                check_outputs("after glitch");
            end
            send_frame(value, !bad_stop);
            if (bad_stop)
                exp_ferr++;
            else if (exp_q.size() != 0)
                exp_overrun = 1'b1;
            else
                exp_q.push_back(value);
            check_outputs("after frame");
            // delay 7 leaves the byte for the next frame to overrun
            if (exp_q.size() != 0 && delay != 7)
                take_byte(int'(delay));
        end
        if (exp_q.size() != 0)
            take_byte(0);

        if (error_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: bench/uart_rx_checker.sv
// bound assertions: vld/rdy handshake, frame_err pulse, overrun flag
`include "uart_rx_settings.svh"

module uart_rx_checker (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       rdy,
    input logic [`UART_DATA_BITS-1:0] data,
    input logic                       vld,
    input logic                       frame_err,
    input logic                       overrun,
    input rx_ctrl_pkg::rx_state_e     state
);

    ////////////////////
    // handshake
    // held byte stays put until rdy
    hold_until_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        vld && !rdy |=> vld && $stable(data))
        else $error("vld or data changed while rdy was low");

    // taken byte leaves the next cycle
    drop_after_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        vld && rdy |=> !vld)
        else $error("vld still high after rdy");

    // a new byte only follows a stop bit sample
    load_after_stop: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(vld) |-> $past(state) == rx_ctrl_pkg::STOP)
        else $error("vld rose without a stop bit sample");

    ////////////////////
    // error and overrun flags
    err_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        frame_err |=> !frame_err)
        else $error("frame_err longer than one cycle");

    overrun_needs_vld: assert property (@(posedge clk) disable iff (!rst_n)
        overrun |-> vld)
        else $error("overrun set with no held byte");

endmodule

bind uart_rx_top uart_rx_checker i_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .rdy       (rdy),
    .data      (data),
    .vld       (vld),
    .frame_err (frame_err),
    .overrun   (overrun),
    .state     (i_fsm.state)
);

// File: project.f
+incdir+verilog
verilog/rx_ctrl_pkg.sv
verilog/rx_data_pkg.sv
verilog/rx_frame_fsm.sv
verilog/rx_bit_timer.sv
verilog/rx_shift_register.sv
verilog/rx_holding_register.sv
verilog/uart_rx_top.sv
bench/uart_rx_checker.sv
bench/tb_uart_rx.sv

// File: verilog/rx_bit_timer.sv
// bit timer: tick counter for half and full bit waits, data bit counter
`include "uart_rx_settings.svh"

module rx_bit_timer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rx_ctrl_pkg::rx_ctrl_t ctrl,
    output rx_ctrl_pkg::rx_tick_t tick
);

    localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
    localparam int BIT_W  = $clog2(`UART_DATA_BITS + 1);

    logic [TICK_W-1:0] tick_cnt;
    logic [TICK_W-1:0] tick_limit;
    logic [BIT_W-1:0]  bit_cnt;
    logic              sample;

    ////////////////////
    // tick counter
    // last count of the current wait
    assign tick_limit = ctrl.half_bit ? TICK_W'(`UART_HALF_BIT - 1)
                                      : TICK_W'(`UART_OVERSAMPLE - 1);
    assign sample = ctrl.timer_run && (tick_cnt == tick_limit);

    always_ff @(posedge clk)
    begin
        if (!rst_n || ctrl.timer_clear)
        begin
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end
        else if (ctrl.timer_run)
        begin
            // wrap on each sample, next wait starts here
            tick_cnt <= sample ? '0 : tick_cnt + 1'b1;
            // half-bit start sample is not a data bit
            if (sample && !ctrl.half_bit)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // events to the FSM
    always_comb
    begin
        tick.sample   = sample;
        tick.last_bit = sample && !ctrl.half_bit &&
                        (bit_cnt == BIT_W'(`UART_DATA_BITS - 1));
    end

endmodule

// File: verilog/rx_ctrl_pkg.sv
// receiver control types: frame state enum, FSM-to-timer and timer-to-FSM structs
package rx_ctrl_pkg;

    ////////////////////
    // frame state
    // idle line, start check, data bits, stop check
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        START = 2'd1,
        DATA  = 2'd2,
        STOP  = 2'd3
    } rx_state_e;

    ////////////////////
    // FSM to timer
    typedef struct packed {
        // keep counting ticks
        logic timer_run;
        // restart tick and bit counts at zero
        logic timer_clear;
        // wait only half a bit, start check
        logic half_bit;
    } rx_ctrl_t;

    // timer to FSM
    typedef struct packed {
        // one cycle, current wait has elapsed
        logic sample;
        // this sample is the final data bit
        logic last_bit;
    } rx_tick_t;

    // FSM to shifter
    typedef struct packed {
        logic shift;
        logic bit_value;
    } rx_shift_t;

endpackage

// File: verilog/rx_data_pkg.sv
// receiver data types: assembled frame passed to the holding register
package rx_data_pkg;

    `include "uart_rx_settings.svh"

    ////////////////////
    // received frame
    // done and stop_ok come from the FSM, data from the shifter
    typedef struct packed {
        // one cycle, stop bit just sampled
        logic done;
        // stop bit was high
        logic stop_ok;
        // LSB is the first bit on the line
        logic [`UART_DATA_BITS-1:0] data;
    } rx_frame_t;

endpackage

// File: verilog/rx_frame_fsm.sv
// frame FSM: rxd synchronizer, start edge detect, false start reject, stop check
`include "uart_rx_settings.svh"

module rx_frame_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rxd,
    input  rx_ctrl_pkg::rx_tick_t tick,
    output rx_ctrl_pkg::rx_ctrl_t ctrl,
    output rx_ctrl_pkg::rx_shift_t shift_cmd,
    output logic                  frame_done,
    output logic                  stop_ok,
    output logic                  frame_err
);

    logic [`UART_SYNC_STAGES-1:0] sync_q;
    logic                         line;
    logic                         line_prev;
    logic                         start_edge;
    rx_ctrl_pkg::rx_state_e       state;
    rx_ctrl_pkg::rx_state_e       state_nxt;

    ////////////////////
    // input synchronizer
    // idle line is high, so reset to ones
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sync_q    <= '1;
            line_prev <= 1'b1;
        end
        else
        begin
            sync_q    <= {sync_q[`UART_SYNC_STAGES-2:0], rxd};
            line_prev <= line;
        end
    end

    assign line = sync_q[`UART_SYNC_STAGES-1];
    // falling edge only, a line stuck low after a bad stop does not restart
    assign start_edge = line_prev & ~line;

    ////////////////////
    // state register
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= rx_ctrl_pkg::IDLE;
        else
            state <= state_nxt;
    end

    // next state
    always_comb
    begin
        state_nxt = state;
        case (state)
            rx_ctrl_pkg::IDLE:
                if (start_edge)
                    state_nxt = rx_ctrl_pkg::START;
            rx_ctrl_pkg::START:
                // still low at mid start bit, else a glitch
                if (tick.sample)
                    state_nxt = line ? rx_ctrl_pkg::IDLE : rx_ctrl_pkg::DATA;
            rx_ctrl_pkg::DATA:
                if (tick.sample && tick.last_bit)
                    state_nxt = rx_ctrl_pkg::STOP;
            default:
                if (tick.sample)
                    state_nxt = rx_ctrl_pkg::IDLE;
        endcase
    end

    ////////////////////
    // timer control and event outputs
    always_comb
    begin
        ctrl.timer_run   = (state != rx_ctrl_pkg::IDLE);
        ctrl.timer_clear = (state == rx_ctrl_pkg::IDLE) && start_edge;
        ctrl.half_bit    = (state == rx_ctrl_pkg::START);
        // one data bit per mid-bit sample
        shift_cmd.shift     = (state == rx_ctrl_pkg::DATA) && tick.sample;
        shift_cmd.bit_value = line;
        frame_done = (state == rx_ctrl_pkg::STOP) && tick.sample;
        stop_ok    = line;
        // low stop bit, frame is thrown away
        frame_err  = frame_done && !line;
    end

endmodule

// File: verilog/rx_holding_register.sv
// output holding register: vld/rdy level handshake and sticky overrun flag
`include "uart_rx_settings.svh"

module rx_holding_register (
    input  logic                       clk,
    input  logic                       rst_n,
    input  rx_data_pkg::rx_frame_t     frame,
    input  logic                       rdy,
    output logic [`UART_DATA_BITS-1:0] data,
    output logic                       vld,
    output logic                       overrun
);

    logic good_frame;

    // bad stop frames never reach the output
    assign good_frame = frame.done && frame.stop_ok;

    ////////////////////
    // handshake state
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            vld     <= 1'b0;
            overrun <= 1'b0;
        end
        else if (vld)
        begin
            if (rdy)
            begin
                // byte taken, flag goes with it
                vld     <= 1'b0;
                overrun <= 1'b0;
            end
            else if (good_frame)
                overrun <= 1'b1;
        end
        else if (good_frame)
            vld <= 1'b1;
    end

    // payload, loaded only when empty
    always_ff @(posedge clk)
    begin
        if (!vld && good_frame)
            data <= frame.data;
    end

endmodule

// File: verilog/rx_shift_register.sv
// serial-to-parallel shifter, bundles the byte with the FSM's done and stop bits
`include "uart_rx_settings.svh"

module rx_shift_register (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rx_ctrl_pkg::rx_shift_t shift_cmd,
    input  logic                   frame_done,
    input  logic                   stop_ok,
    output rx_data_pkg::rx_frame_t frame
);

    logic [`UART_DATA_BITS-1:0] shreg;

    ////////////////////
    // shifter
    // enters at the top, first bit lands in the LSB
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            shreg <= '0;
        else if (shift_cmd.shift)
            shreg <= {shift_cmd.bit_value, shreg[`UART_DATA_BITS-1:1]};
    end

    // frame to holding register
    always_comb
    begin
        frame.done    = frame_done;
        frame.stop_ok = stop_ok;
        // all eight bits in by the stop sample
        frame.data    = shreg;
    end

endmodule

// File: verilog/uart_rx_settings.svh
// uart receiver settings macros: oversampling, half-bit point, data bits, sync depth
`ifndef UART_RX_SETTINGS_SVH
`define UART_RX_SETTINGS_SVH

////////////////////
// bit timing
// clk is already the 16x sample clock
`define UART_OVERSAMPLE 16
// start-bit middle, also the shortest start accepted
`define UART_HALF_BIT 8

////////////////////
// frame shape and input
// 8N1 only
`define UART_DATA_BITS 8
// flops between rxd pin and the FSM
`define UART_SYNC_STAGES 2

`endif

// File: verilog/uart_rx_top.sv
// uart receiver top: frame FSM, bit timer, shifter and holding register
`include "uart_rx_settings.svh"

module uart_rx_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       rxd,
    input  logic                       rdy,
    output logic [`UART_DATA_BITS-1:0] data,
    output logic                       vld,
    output logic                       frame_err,
    output logic                       overrun
);

    rx_ctrl_pkg::rx_ctrl_t  ctrl;
    rx_ctrl_pkg::rx_tick_t  tick;
    rx_ctrl_pkg::rx_shift_t shift_cmd;
    rx_data_pkg::rx_frame_t frame;
    logic                   frame_done;
    logic                   stop_ok;

    ////////////////////
    // control path
    rx_frame_fsm i_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .rxd        (rxd),
        .tick       (tick),
        .ctrl       (ctrl),
        .shift_cmd  (shift_cmd),
        .frame_done (frame_done),
        .stop_ok    (stop_ok),
        .frame_err  (frame_err)
    );

    rx_bit_timer i_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (ctrl),
        .tick  (tick)
    );

    // data path
    rx_shift_register i_shift (
        .clk        (clk),
        .rst_n      (rst_n),
        .shift_cmd  (shift_cmd),
        .frame_done (frame_done),
        .stop_ok    (stop_ok),
        .frame      (frame)
    );

    rx_holding_register i_hold (
        .clk     (clk),
        .rst_n   (rst_n),
        .frame   (frame),
        .rdy     (rdy),
        .data    (data),
        .vld     (vld),
        .overrun (overrun)
    );

endmodule
